// ==== sya_skew.f ====
+incdir+verif
common/skew_cfg_pkg.sv
common/skew_ctrl_pkg.sv
hw/skew_buffer/bank_ram.sv
hw/skew_buffer/skew_buffer.sv
hw/cfg_regs.sv
hw/sya_skew_top.sv
verif/tb_sya_skew.sv

// ==== Bender.yml ====
package:
  name: sya_skew

sources:
  # Shared packages first
  - files:
      - common/skew_cfg_pkg.sv
      - common/skew_ctrl_pkg.sv

  # Design
  - files:
      - hw/skew_buffer/bank_ram.sv
      - hw/skew_buffer/skew_buffer.sv
      - hw/cfg_regs.sv
      - hw/sya_skew_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_sya_skew.sv

// ==== verif/sya_skew_model.svh ====
// Reference model of the skew banks: lane address rules, bank contents, expected read words
`ifndef SYA_SKEW_MODEL_SVH
`define SYA_SKEW_MODEL_SVH

typedef logic [LANES-1:0][DATA_W-1:0] beat_t;

logic [DATA_W-1:0] mdl_mem  [LANES][DEPTH];
bit                mdl_seen [LANES][DEPTH];  // Written since reset
int                mdl_ptr = 0;              // Beats accepted this frame
int                mdl_grp = 0;              // Triangle group offset

// Bank address of one lane for write pointer p
function automatic int lane_addr(int lane, int p, int grp, bit rect, int bs, int ws);
    int sum;
    if (rect) begin
        sum = p + bs * lane;
        if (sum >= bs * ws) sum = sum - bs * ws;  // Single wrap into the rectangle
    end else begin
        sum = p - bs * lane + grp;                 // Skew down by lane
    end
    return ((sum % DEPTH) + DEPTH) % DEPTH;
endfunction

// One accepted beat into the model banks
function automatic void scatter_beat(beat_t beat, bit rect, int bs, int ws);
    int p;
    int a;
    p = mdl_ptr % DEPTH;
    for (int i = 0; i < LANES; i++) begin
        a = lane_addr(i, p, mdl_grp, rect, bs, ws);
        mdl_mem[i][a]  = beat[i];
        mdl_seen[i][a] = 1'b1;
    end
    // Group step at the end of each wb_step stripe
    if (bs * ws != 0 && (p % (bs * ws)) == ws - bs) mdl_grp = (mdl_grp + 1) % DEPTH;
    mdl_ptr = mdl_ptr + 1;
endfunction

// Frame done or cleared, pointer and group back to 0
function automatic void restart_frame();
    mdl_ptr = 0;
    mdl_grp = 0;
endfunction

// First lane that differs from the model, -1 if none
function automatic int word_mismatch(int addr, beat_t word);
    for (int i = 0; i < LANES; i++) begin
        if (mdl_seen[i][addr] && word[i] !== mdl_mem[i][addr]) return i;
    end
    return -1;
endfunction

`endif

// ==== verif/tb_sya_skew.sv ====
// Testbench for the skew buffer top level: LFSR stimulus, AXI4-Lite tasks, model checks
`timescale 1ns/1ps
`default_nettype none

module tb_sya_skew
    import skew_cfg_pkg::*;
    import skew_ctrl_pkg::*;
();

    localparam int LANES  = DEF_LANES;
    localparam int DATA_W = DEF_DATA_W;
    localparam int ADDR_W = DEF_ADDR_W;
    localparam int DEPTH  = 2**ADDR_W;
    localparam int MAX_BEATS  = 40;   // Longest frame below
    localparam int MAX_RD_LEN = 64;
    localparam int N_FRAMES   = 5;    // Including the aborted one
    localparam int WATCHDOG_CYCLES = N_FRAMES * (MAX_BEATS + MAX_RD_LEN) * 4 + 1000;

    `include "sya_skew_model.svh"

    logic clk, rst_n;
    logic [AXIL_ADDR_W-1:0] s_awaddr_i, s_araddr_i;
    logic [AXIL_DATA_W-1:0] s_wdata_i, s_rdata_o;
    logic [3:0] s_wstrb_i;
    logic [1:0] s_bresp_o, s_rresp_o;
    logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
    logic s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
    beat_t din_i, dout_o;
    logic din_valid_i, din_last_i, din_ready_o, dout_valid_o, dout_ready_i;

    logic [31:0] lfsr_q = 32'h73e;
    int err_cnt = 0;
    int test_err = 0;   // Errors before the running test
    int n_tests = 0;
    int words = 0;      // Read words compared
    bit cfg_rect;
    int cfg_bs, cfg_ws, cfg_len;

    sya_skew_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    // Galois LFSR x^32+x^22+x^2+x+1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic report_fail(input string msg);
        err_cnt++;
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        $display("test %-12s %s, %0d errors", name,
                 (err_cnt == test_err) ? "ok" : "failed", err_cnt - test_err);
        test_err = err_cnt;
        n_tests++;
    endtask

    // AXI4-Lite write entered and left 2 ns after a rising edge
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        bit aw_ok, w_ok;
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_wstrb_i   = 4'hf;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        s_bready_i  = 1'b1;
        while (s_awvalid_i || s_wvalid_i) begin
            @(negedge clk);  // Handshakes sampled mid cycle
            aw_ok = s_awvalid_i && s_awready_o;
            w_ok  = s_wvalid_i && s_wready_o;
            @(posedge clk);
            #2;
            if (aw_ok) s_awvalid_i = 1'b0;
            if (w_ok) s_wvalid_i = 1'b0;
        end
        @(negedge clk);
        while (!s_bvalid_o) @(negedge clk);
        resp = s_bresp_o;
        @(posedge clk);
        #2;
        s_bready_i = 1'b0;
    endtask

    // Register write with the response it must get
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        if (resp !== exp_resp)
            report_fail($sformatf("reg 0x%02h write resp %0d, expected resp %0d",
                                  addr, resp, exp_resp));
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        bit ar_ok;
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        s_rready_i  = 1'b1;
        ar_ok = 1'b0;
        while (!ar_ok) begin
            @(negedge clk);
            ar_ok = s_arready_o;
            @(posedge clk);
            #2;
        end
        s_arvalid_i = 1'b0;
        @(negedge clk);
        while (!s_rvalid_o) @(negedge clk);
        data = s_rdata_o;
        resp = s_rresp_o;
        @(posedge clk);
        #2;
        s_rready_i = 1'b0;
    endtask

    task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp,
                              input logic [1:0] exp_resp);
        logic [31:0] got;
        logic [1:0]  resp;
        axil_read(addr, got, resp);
        if (resp !== exp_resp || (exp_resp == RESP_OKAY && got !== exp))
            report_fail($sformatf("reg 0x%02h read 0x%08h resp %0d, expected 0x%08h resp %0d",
                                  addr, got, resp, exp, exp_resp));
    endtask

    task automatic configure(input bit rect, input int bs, input int ws, input int len);
        cfg_rect = rect;
        cfg_bs   = bs;
        cfg_ws   = ws;
        cfg_len  = len;
        write_reg(REG_CTRL, {31'b0, rect}, RESP_OKAY);
        write_reg(REG_BYTE_STEP, bs, RESP_OKAY);
        write_reg(REG_WB_STEP, ws, RESP_OKAY);
        write_reg(REG_RD_LEN, len, RESP_OKAY);
    endtask

    // Random beats with random valid gaps into both DUT and model
    task automatic write_frame(input int n_beats, input bit with_last);
        int sent;
        bit took;
        sent = 0;
        while (sent < n_beats) begin
            if (!din_valid_i) begin
                for (int i = 0; i < LANES; i++) begin
                    din_i[i] = DATA_W'(rand_bits(DATA_W));
                end
                din_valid_i = rand_bits(1) != 0;
                din_last_i  = with_last && (sent == n_beats - 1);
            end
            @(negedge clk);
            if (din_valid_i && !din_ready_o) report_fail("din_ready_o low in write phase");
            took = din_valid_i && din_ready_o;
            if (took) begin
                scatter_beat(din_i, cfg_rect, cfg_bs, cfg_ws);
                sent++;
            end
            @(posedge clk);
            #2;
            if (took) begin
                din_valid_i = 1'b0;
                din_last_i  = 1'b0;
            end
        end
    endtask

    // Sweep of cfg_len words with optional random back-pressure
    task automatic read_frame(input bit bp);
        int    k;
        int    bad;
        bit    held;
        beat_t held_word;
        k    = 0;
        held = 1'b0;
        while (k < cfg_len) begin
            dout_ready_i = bp ? (rand_bits(1) != 0) : 1'b1;
            @(negedge clk);
            if (din_ready_o) report_fail("din_ready_o high in read phase");
            if (held && (!dout_valid_o || dout_o !== held_word))
                report_fail($sformatf("held word at address %0d changed or dropped", k));
            if (!bp && k > 0 && !dout_valid_o)
                report_fail($sformatf("no word at address %0d with dout_ready_i high", k));
            if (dout_valid_o && dout_ready_i) begin
                bad = word_mismatch(k, dout_o);
                if (bad >= 0)
                    report_fail($sformatf("address %0d lane %0d read 0x%02h, expected 0x%02h",
                                          k, bad, dout_o[bad], mdl_mem[bad][k]));
                k++;
                words++;
            end
            held      = dout_valid_o && !dout_ready_i;
            held_word = dout_o;
            @(posedge clk);
            #2;
        end
        dout_ready_i = 1'b0;
        restart_frame();
        @(negedge clk);
        if (dout_valid_o || !din_ready_o)
            report_fail("buffer still in read phase after the last word");
        @(posedge clk);
        #2;
        expect_reg(REG_STATUS, 32'h0, RESP_OKAY);  // Write phase with count cleared
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin : main
        logic [31:0] v;
        int nb, bs, ws, m;
        rst_n = 1'b0;
        s_awaddr_i = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i = '0;
        s_wstrb_i = '0;
        s_wvalid_i = 1'b0;
        s_bready_i = 1'b0;
        s_araddr_i = '0;
        s_arvalid_i = 1'b0;
        s_rready_i = 1'b0;
        din_i = '0;
        din_valid_i = 1'b0;
        din_last_i = 1'b0;
        dout_ready_i = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        if (!din_ready_o || dout_valid_o || s_bvalid_o || s_rvalid_o)
            report_fail("handshake outputs not idle after reset");

        // Reset values, read back, error responses
        expect_reg(REG_CTRL, 32'h0, RESP_OKAY);
        expect_reg(REG_BYTE_STEP, 32'h1, RESP_OKAY);
        expect_reg(REG_WB_STEP, LANES, RESP_OKAY);
        expect_reg(REG_RD_LEN, 32'h0, RESP_OKAY);
        expect_reg(REG_STATUS, 32'h0, RESP_OKAY);
        v = rand_bits(32);
        write_reg(REG_BYTE_STEP, v, RESP_OKAY);
        expect_reg(REG_BYTE_STEP, v & (DEPTH - 1), RESP_OKAY);
        v = rand_bits(32);
        write_reg(REG_WB_STEP, v, RESP_OKAY);
        expect_reg(REG_WB_STEP, v & (DEPTH - 1), RESP_OKAY);
        v = rand_bits(32);
        write_reg(REG_RD_LEN, v, RESP_OKAY);
        expect_reg(REG_RD_LEN, v & (2 * DEPTH - 1), RESP_OKAY);
        write_reg(REG_CTRL, 32'h1, RESP_OKAY);
        expect_reg(REG_CTRL, 32'h1, RESP_OKAY);
        write_reg(8'h14, 32'h0, RESP_SLVERR);
        write_reg(REG_STATUS, 32'h0, RESP_SLVERR);
        expect_reg(8'h20, 32'h0, RESP_SLVERR);
        end_test("registers");

        // Triangle skew with unit step
        nb = 16 + rand_bits(4);
        configure(1'b0, 1, LANES, nb + LANES);
        write_frame(nb, 1'b1);
        read_frame(1'b0);
        end_test("triangle");

        // Rectangle with product kept within the depth
        bs = 1 + rand_bits(3) % 7;
        ws = 1 + rand_bits(6) % ((DEPTH - 1) / bs);
        nb = 8 + rand_bits(5);
        configure(1'b1, bs, ws, DEPTH);
        write_frame(nb, 1'b1);
        read_frame(1'b0);
        end_test("rectangle");

        nb = 16 + rand_bits(4);
        configure(1'b0, 1, LANES, DEPTH);
        write_frame(nb, 1'b1);
        read_frame(1'b1);
        end_test("backpressure");

        // Abort a partial frame and then run a clean one from pointer 0
        m = 5 + rand_bits(3);
        configure(1'b0, 1, LANES, 40);
        write_frame(m, 1'b0);
        expect_reg(REG_STATUS, m << STATUS_CNT_LSB, RESP_OKAY);
        write_reg(REG_CTRL, 32'h2, RESP_OKAY);
        restart_frame();
        expect_reg(REG_STATUS, 32'h0, RESP_OKAY);
        nb = 16 + rand_bits(4);
        write_frame(nb, 1'b1);
        read_frame(1'b1);
        end_test("soft_clear");

        $display("tests %0d, words checked %0d, errors %0d", n_tests, words, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule : tb_sya_skew

`default_nettype wire

// ==== hw/sya_skew_top.sv ====
// Top level joining the register slave and the skew buffer
`timescale 1ns/1ps
`default_nettype none

module sya_skew_top
    import skew_cfg_pkg::*;
    import skew_ctrl_pkg::*;
#(
    parameter int LANES  = DEF_LANES,
    parameter int DATA_W = DEF_DATA_W,
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  wire                          clk,
    input  wire                          rst_n,
    // AXI4-Lite slave
    input  wire [AXIL_ADDR_W-1:0]        s_awaddr_i,
    input  wire                          s_awvalid_i,
    output logic                         s_awready_o,
    input  wire [AXIL_DATA_W-1:0]        s_wdata_i,
    input  wire [AXIL_DATA_W/8-1:0]      s_wstrb_i,
    input  wire                          s_wvalid_i,
    output logic                         s_wready_o,
    output logic [1:0]                   s_bresp_o,
    output logic                         s_bvalid_o,
    input  wire                          s_bready_i,
    input  wire [AXIL_ADDR_W-1:0]        s_araddr_i,
    input  wire                          s_arvalid_i,
    output logic                         s_arready_o,
    output logic [AXIL_DATA_W-1:0]       s_rdata_o,
    output logic [1:0]                   s_rresp_o,
    output logic                         s_rvalid_o,
    input  wire                          s_rready_i,
    // Data in and out
    input  wire [LANES-1:0][DATA_W-1:0]  din_i,
    input  wire                          din_valid_i,
    input  wire                          din_last_i,
    output logic                         din_ready_o,
    output logic [LANES-1:0][DATA_W-1:0] dout_o,
    output logic                         dout_valid_o,
    input  wire                          dout_ready_i
);

    logic   rect_mode, soft_clear;
    addr_t  byte_step, wb_step;
    cnt_t   rd_len, beat_cnt;
    phase_e phase;

    cfg_regs #(
        .LANES (LANES)
    ) u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .s_awaddr_i   (s_awaddr_i),
        .s_awvalid_i  (s_awvalid_i),
        .s_awready_o  (s_awready_o),
        .s_wdata_i    (s_wdata_i),
        .s_wstrb_i    (s_wstrb_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wready_o   (s_wready_o),
        .s_bresp_o    (s_bresp_o),
        .s_bvalid_o   (s_bvalid_o),
        .s_bready_i   (s_bready_i),
        .s_araddr_i   (s_araddr_i),
        .s_arvalid_i  (s_arvalid_i),
        .s_arready_o  (s_arready_o),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .s_rvalid_o   (s_rvalid_o),
        .s_rready_i   (s_rready_i),
        .rect_mode_o  (rect_mode),
        .byte_step_o  (byte_step),
        .wb_step_o    (wb_step),
        .rd_len_o     (rd_len),
        .soft_clear_o (soft_clear),
        .phase_i      (phase),
        .beat_cnt_i   (beat_cnt)
    );

    skew_buffer #(
        .LANES  (LANES),
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_skew (
        .clk          (clk),
        .rst_n        (rst_n),
        .rect_mode_i  (rect_mode),
        .byte_step_i  (byte_step),
        .wb_step_i    (wb_step),
        .rd_len_i     (rd_len),
        .soft_clear_i (soft_clear),
        .din_i        (din_i),
        .din_valid_i  (din_valid_i),
        .din_last_i   (din_last_i),
        .din_ready_o  (din_ready_o),
        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .dout_ready_i (dout_ready_i),
        .phase_o      (phase),
        .beat_cnt_o   (beat_cnt)
    );

endmodule : sya_skew_top

`default_nettype wire

// ==== hw/cfg_regs.sv ====
// AXI4-Lite register slave for mode, steps, read length and status
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
    import skew_cfg_pkg::*;
    import skew_ctrl_pkg::*;
#(
    parameter int LANES = DEF_LANES
) (
    input  wire                     clk,
    input  wire                     rst_n,
    // AXI4-Lite slave
    input  wire [AXIL_ADDR_W-1:0]   s_awaddr_i,
    input  wire                     s_awvalid_i,
    output logic                    s_awready_o,
    input  wire [AXIL_DATA_W-1:0]   s_wdata_i,
    input  wire [AXIL_DATA_W/8-1:0] s_wstrb_i,
    input  wire                     s_wvalid_i,
    output logic                    s_wready_o,
    output logic [1:0]              s_bresp_o,
    output logic                    s_bvalid_o,
    input  wire                     s_bready_i,
    input  wire [AXIL_ADDR_W-1:0]   s_araddr_i,
    input  wire                     s_arvalid_i,
    output logic                    s_arready_o,
    output logic [AXIL_DATA_W-1:0]  s_rdata_o,
    output logic [1:0]              s_rresp_o,
    output logic                    s_rvalid_o,
    input  wire                     s_rready_i,
    // Configuration out
    output logic                    rect_mode_o,
    output addr_t                   byte_step_o,
    output addr_t                   wb_step_o,
    output cnt_t                    rd_len_o,
    output logic                    soft_clear_o,
    // Status in
    input  wire phase_e             phase_i,
    input  wire cnt_t               beat_cnt_i
);

    logic                   aw_done_q, w_done_q;   // Channel already taken
    logic [AXIL_ADDR_W-1:0] awaddr_q, wr_addr;
    logic [AXIL_DATA_W-1:0] wdata_q, wr_data, rd_word;
    logic                   wstrb0_q, wr_strb0;
    logic                   aw_fire, w_fire, wr_go, wr_ok, rd_ok;

    // =========================================================================
    // Write side
    // =========================================================================
    assign s_awready_o = !aw_done_q && !s_bvalid_o;
    assign s_wready_o  = !w_done_q && !s_bvalid_o;
    assign aw_fire     = s_awvalid_i && s_awready_o;
    assign w_fire      = s_wvalid_i && s_wready_o;
    assign wr_go       = (aw_done_q || aw_fire) && (w_done_q || w_fire);

    // Held copy or live bus
    assign wr_addr  = aw_done_q ? awaddr_q : s_awaddr_i;
    assign wr_data  = w_done_q ? wdata_q : s_wdata_i;
    assign wr_strb0 = w_done_q ? wstrb0_q : s_wstrb_i[0];
    assign wr_ok    = wr_addr inside {REG_CTRL, REG_BYTE_STEP, REG_WB_STEP, REG_RD_LEN};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_done_q    <= 1'b0;
            w_done_q     <= 1'b0;
            s_bvalid_o   <= 1'b0;
            s_bresp_o    <= RESP_OKAY;
            rect_mode_o  <= 1'b0;          // Triangle
            byte_step_o  <= addr_t'(1);
            wb_step_o    <= addr_t'(LANES);
            rd_len_o     <= '0;
            soft_clear_o <= 1'b0;
        end else begin
            soft_clear_o <= 1'b0;          // Pulse only
            if (s_bvalid_o && s_bready_i) s_bvalid_o <= 1'b0;
            if (wr_go) begin
                aw_done_q  <= 1'b0;
                w_done_q   <= 1'b0;
                s_bvalid_o <= 1'b1;
                s_bresp_o  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                if (wr_strb0) begin        // All fields sit in byte 0
                    case (wr_addr)
                        REG_CTRL: begin
                            rect_mode_o  <= wr_data[CTRL_RECT_BIT];
                            soft_clear_o <= wr_data[CTRL_CLEAR_BIT];
                        end
                        REG_BYTE_STEP: byte_step_o <= addr_t'(wr_data);
                        REG_WB_STEP:   wb_step_o   <= addr_t'(wr_data);
                        REG_RD_LEN:    rd_len_o    <= cnt_t'(wr_data);
                        default: ;                 // Error already flagged
                    endcase
                end
            end else begin
                if (aw_fire) aw_done_q <= 1'b1;
                if (w_fire)  w_done_q  <= 1'b1;
            end
        end
    end

    // Payload holding, no reset
    always_ff @(posedge clk) begin
        if (aw_fire) awaddr_q <= s_awaddr_i;
        if (w_fire) begin
            wdata_q  <= s_wdata_i;
            wstrb0_q <= s_wstrb_i[0];
        end
    end

    // =========================================================================
    // Read side
    // =========================================================================
    always_comb begin
        rd_word = '0;
        rd_ok   = 1'b1;
        case (s_araddr_i)
            REG_CTRL:      rd_word[CTRL_RECT_BIT] = rect_mode_o;  // Clear bit reads 0
            REG_BYTE_STEP: rd_word = AXIL_DATA_W'(byte_step_o);
            REG_WB_STEP:   rd_word = AXIL_DATA_W'(wb_step_o);
            REG_RD_LEN:    rd_word = AXIL_DATA_W'(rd_len_o);
            REG_STATUS: begin
                rd_word[0] = phase_i;
                rd_word[STATUS_CNT_LSB +: $bits(cnt_t)] = beat_cnt_i;
            end
            default:       rd_ok = 1'b0;
        endcase
    end

    assign s_arready_o = !s_rvalid_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_rvalid_o <= 1'b0;
            s_rresp_o  <= RESP_OKAY;
            s_rdata_o  <= '0;
        end else if (s_arvalid_i && s_arready_o) begin
            s_rvalid_o <= 1'b1;
            s_rresp_o  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            s_rdata_o  <= rd_word;
        end else if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
        end
    end

    // Write response waits for the master
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

endmodule : cfg_regs

`default_nettype wire

// ==== hw/skew_buffer/skew_buffer.sv ====
// Phase FSM, write/read pointers, group counter, lane address scatter and bank array
`timescale 1ns/1ps
`default_nettype none

module skew_buffer
    import skew_cfg_pkg::*;
    import skew_ctrl_pkg::*;
#(
    parameter int LANES  = DEF_LANES,
    parameter int DATA_W = DEF_DATA_W,
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  wire                          clk,
    input  wire                          rst_n,
    // Configuration
    input  wire                          rect_mode_i,
    input  wire addr_t                   byte_step_i,
    input  wire addr_t                   wb_step_i,
    input  wire cnt_t                    rd_len_i,
    input  wire                          soft_clear_i,
    // Beat input
    input  wire [LANES-1:0][DATA_W-1:0]  din_i,
    input  wire                          din_valid_i,
    input  wire                          din_last_i,
    output logic                         din_ready_o,
    // Skewed word output
    output logic [LANES-1:0][DATA_W-1:0] dout_o,
    output logic                         dout_valid_o,
    input  wire                          dout_ready_i,
    // Status
    output phase_e                       phase_o,
    output cnt_t                         beat_cnt_o
);

    localparam int DEPTH = 2**ADDR_W;
    localparam int MW    = 2*ADDR_W + $clog2(LANES) + 2;  // Room for step products

    phase_e         phase_q, phase_d;
    cnt_t           beat_cnt_q;        // Beats this frame whose low bits are the write pointer
    addr_t          wr_ptr;
    addr_t          grp_q;             // Triangle wrap groups done
    cnt_t           rd_ptr_q;          // Next address to issue
    cnt_t           out_cnt_q;         // Words handed out
    logic [MW-1:0]  lim_w;             // byte_step * wb_step
    logic           push, pop, issue, rd_en, rd_done, grp_hit;
    logic [LANES-1:0] bank_valid, bank_accept;
    addr_t          wr_addr [LANES];

    // =========================================================================
    // Handshakes
    // =========================================================================
    assign din_ready_o  = (phase_q == PH_WRITE);
    assign push         = din_valid_i && din_ready_o;
    assign dout_valid_o = &bank_valid;
    assign pop          = dout_valid_o && dout_ready_i;

    // Issue a bank read while addresses remain
    assign rd_en = (phase_q == PH_READ) && (rd_ptr_q < rd_len_i) && !soft_clear_i;
    assign issue = rd_en && (&bank_accept);

    // Last word taken or nothing to read
    assign rd_done = (phase_q == PH_READ) &&
                     ((rd_len_i == '0) || (pop && out_cnt_q == rd_len_i - 1'b1));

    assign wr_ptr  = addr_t'(beat_cnt_q);
    assign lim_w   = MW'(byte_step_i) * MW'(wb_step_i);
    assign grp_hit = (lim_w != '0) &&
                     ((MW'(wr_ptr) % lim_w) == MW'(wb_step_i) - MW'(byte_step_i));

    // =========================================================================
    // Phase FSM
    // =========================================================================
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_WRITE: if (push && din_last_i) phase_d = PH_READ;
            PH_READ:  if (rd_done) phase_d = PH_WRITE;
        endcase
        if (soft_clear_i) begin
            phase_d = PH_WRITE;  // Abort from anywhere
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q    <= PH_WRITE;
            beat_cnt_q <= '0;
            grp_q      <= '0;
            rd_ptr_q   <= '0;
            out_cnt_q  <= '0;
        end else begin
            phase_q <= phase_d;
            if (soft_clear_i || rd_done) begin
                beat_cnt_q <= '0;  // New frame from address 0
                grp_q      <= '0;
                rd_ptr_q   <= '0;
                out_cnt_q  <= '0;
            end else begin
                if (push) begin
                    beat_cnt_q <= beat_cnt_q + 1'b1;
                    if (grp_hit) begin
                        grp_q <= grp_q + 1'b1;
                    end
                end
                if (issue) rd_ptr_q <= rd_ptr_q + 1'b1;
                if (pop)   out_cnt_q <= out_cnt_q + 1'b1;
            end
        end
    end

    assign phase_o    = phase_q;
    assign beat_cnt_o = beat_cnt_q;

    // =========================================================================
    // Lane address scatter and banks
    // =========================================================================
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic [MW-1:0] off, sum;

        assign off = MW'(byte_step_i) * MW'(i);
        assign sum = MW'(wr_ptr) + off;

        // Rectangle wraps once at the product and triangle skews by lane
        assign wr_addr[i] = rect_mode_i ? addr_t'((sum >= lim_w) ? sum - lim_w : sum)
                                        : addr_t'(MW'(wr_ptr) - off + MW'(grp_q));

        bank_ram #(
            .DATA_W (DATA_W),
            .ADDR_W (ADDR_W)
        ) u_bank (
            .clk         (clk),
            .rst_n       (rst_n),
            .wr_en_i     (push),
            .wr_addr_i   (wr_addr[i]),
            .wr_data_i   (din_i[i]),
            .rd_en_i     (rd_en),
            .rd_addr_i   (addr_t'(rd_ptr_q)),   // Same address in every bank
            .rd_data_o   (dout_o[i]),
            .rd_valid_o  (bank_valid[i]),
            .rd_ready_i  (dout_ready_i || soft_clear_i),  // Clear flushes held word
            .rd_accept_o (bank_accept[i])
        );
    end

    // At most one issued word not yet taken
    a_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        rd_ptr_q - out_cnt_q <= cnt_t'(1));

    // Rectangle must fit in the banks
    a_rect_fits: assert property (@(posedge clk) disable iff (!rst_n)
        rect_mode_i && push |-> lim_w <= MW'(DEPTH));

endmodule : skew_buffer

`default_nettype wire

// ==== hw/skew_buffer/bank_ram.sv ====
// Single lane storage bank with registered read port and output hold
`timescale 1ns/1ps
`default_nettype none

module bank_ram
    import skew_cfg_pkg::*;
#(
    parameter int DATA_W = DEF_DATA_W,
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  wire               clk,
    input  wire               rst_n,
    // Write port
    input  wire               wr_en_i,
    input  wire addr_t        wr_addr_i,
    input  wire [DATA_W-1:0]  wr_data_i,
    // Read port
    input  wire               rd_en_i,
    input  wire addr_t        rd_addr_i,
    output logic [DATA_W-1:0] rd_data_o,
    output logic              rd_valid_o,
    input  wire               rd_ready_i,
    output logic              rd_accept_o
);

    localparam int DEPTH = 2**ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];  // No reset on storage

    // Output register free, or emptying this cycle
    assign rd_accept_o = !rd_valid_o || rd_ready_i;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        if (rd_en_i && rd_accept_o) begin
            rd_data_o <= mem[rd_addr_i];  // One cycle latency
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_o <= 1'b0;
        end else if (rd_accept_o) begin
            rd_valid_o <= rd_en_i;  // Refill or drain
        end
    end

    // Stalled word stays put until taken
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o));

endmodule : bank_ram

`default_nettype wire

// ==== common/skew_ctrl_pkg.sv ====
// Buffer phase enum, register map offsets, field positions and AXI response codes
`default_nettype none

package skew_ctrl_pkg;

    // Write phase fills the banks, read phase sweeps them
    typedef enum logic {
        PH_WRITE = 1'b0,
        PH_READ  = 1'b1
    } phase_e;

    // Register offsets, byte addressed
    localparam logic [7:0] REG_CTRL      = 8'h00;
    localparam logic [7:0] REG_BYTE_STEP = 8'h04;
    localparam logic [7:0] REG_WB_STEP   = 8'h08;
    localparam logic [7:0] REG_RD_LEN    = 8'h0C;
    localparam logic [7:0] REG_STATUS    = 8'h10;  // Read only

    // Field positions
    localparam int CTRL_RECT_BIT  = 0;  // Rectangle mode
    localparam int CTRL_CLEAR_BIT = 1;  // Soft clear, self clearing
    localparam int STATUS_CNT_LSB = 8;  // Beat count starts here

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage : skew_ctrl_pkg

`default_nettype wire

// ==== common/skew_cfg_pkg.sv ====
// Default sizes, lane/address/count typedefs and AXI4-Lite widths
`default_nettype none

package skew_cfg_pkg;

    // =========================================================================
    // Default array geometry
    // =========================================================================
    localparam int DEF_LANES  = 8;  // Lanes per beat
    localparam int DEF_DATA_W = 8;  // Bits per lane value
    localparam int DEF_ADDR_W = 6;  // Bank address bits, 64 deep

    // One lane value at the default width
    typedef logic [DEF_DATA_W-1:0] lane_t;

    // Bank address and address-plus-one counts
    typedef logic [DEF_ADDR_W-1:0] addr_t;
    typedef logic [DEF_ADDR_W:0]   cnt_t;  // Holds 0 .. depth inclusive

    // =========================================================================
    // Register bus
    // =========================================================================
    localparam int AXIL_ADDR_W = 8;   // Byte address into the register file
    localparam int AXIL_DATA_W = 32;

endpackage : skew_cfg_pkg

`default_nettype wire
